// ==== design/burst_counter.sv ====
// Loadable down-counter for the burst controller
// Counts remaining reads during a fetch and the wait during drain

`timescale 1ns/1ps
`default_nettype none

module burst_counter #(
    parameter int WID = 8
) (
    input  logic           clk,
    input  logic           srst,
    input  logic           load,
    input  logic [WID-1:0] load_val,
    input  logic           dec,
    output logic           zero
);
    logic [WID-1:0] cnt;

    always_ff @(posedge clk) begin
        if (srst) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= load_val;
        end else if (dec && (cnt != '0)) begin
            // Saturate at zero
            cnt <= cnt - 1'b1;
        end
    end

    assign zero = (cnt == '0);

    // The controller must stop issuing once the count has run out
    a_no_dec_at_zero : assert property (@(posedge clk) disable iff (srst)
        (dec && !load) |-> !zero)
        else $error("burst_counter: decrement at zero");

endmodule : burst_counter

`default_nettype wire

// ==== design/fifo_core.sv ====
// Synchronous FIFO with a first-word-fall-through output register
// The count output covers the buffer plus the output register
// Writes into a full FIFO are dropped and flagged on oflow for a cycle,
// reads while empty are ignored

`timescale 1ns/1ps
`default_nettype none

module fifo_core #(
    parameter int                      DATA_WID    = 32,
    parameter int                      DEPTH       = 8,
    parameter prefetch_pkg::opt_mode_t WR_OPT_MODE = prefetch_pkg::OPT_MODE_TIMING,
    parameter prefetch_pkg::opt_mode_t RD_OPT_MODE = prefetch_pkg::OPT_MODE_TIMING
) (
    input  logic                         clk,
    input  logic                         srst,
    input  logic                         wr,
    input  logic [DATA_WID-1:0]          wr_data,
    input  logic                         rd,
    output logic [$clog2(DEPTH+2)-1:0]   count,
    output logic                         rd_vld,
    output logic [DATA_WID-1:0]          rd_data,
    output logic                         oflow
);
    import prefetch_pkg::*;

    localparam int PTR_WID   = $clog2(DEPTH);
    localparam int MEM_DEPTH = 2**PTR_WID;
    localparam int CNT_WID   = $clog2(DEPTH+2);

    logic [DATA_WID-1:0] mem [MEM_DEPTH];
    // Extra pointer bit tells full from empty
    logic [PTR_WID:0]    wr_ptr;
    logic [PTR_WID:0]    wr_ptr_q;
    logic [PTR_WID:0]    wr_ptr_vis;
    logic [PTR_WID:0]    rd_ptr;
    logic [CNT_WID-1:0]  level;
    logic                wr_ok;
    logic                rd_ok;
    logic                buf_avail;
    logic                load_out;

    // ------------------------------------------------------------------------
    // Accept logic
    // ------------------------------------------------------------------------
    // Underflow protection, pop only a valid head
    assign rd_ok = rd && rd_vld;

    // Write side view of the fill level
    // LATENCY mode lets a pop free its slot in the same cycle
    assign count = (RD_OPT_MODE == OPT_MODE_TIMING) ? level : level - CNT_WID'(rd_ok);

    // Overflow protection
    assign wr_ok = wr && (count < CNT_WID'(DEPTH));

    // Write pointer as seen by the read side
    // TIMING adds one register stage before a new word shows up
    assign wr_ptr_vis = (WR_OPT_MODE == OPT_MODE_TIMING) ? wr_ptr_q : wr_ptr;
    assign buf_avail  = (wr_ptr_vis != rd_ptr);

    // Refill the output register when empty or being popped
    assign load_out = buf_avail && (!rd_vld || rd_ok);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr[PTR_WID-1:0]] <= wr_data;
        end
        if (load_out) begin
            rd_data <= mem[rd_ptr[PTR_WID-1:0]];
        end
    end

    // ------------------------------------------------------------------------
    // Pointers, level and flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr   <= '0;
            wr_ptr_q <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            rd_vld   <= 1'b0;
            oflow    <= 1'b0;
        end else begin
            wr_ptr_q <= wr_ptr;
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load_out) begin
                rd_ptr <= rd_ptr + 1'b1;
                rd_vld <= 1'b1;
            end else if (rd_ok) begin
                rd_vld <= 1'b0;
            end
            level <= level + CNT_WID'(wr_ok) - CNT_WID'(rd_ok);
            // Dropped write
            oflow <= wr && !wr_ok;
        end
    end

    // Head word must always be backed by the level register
    a_vld_needs_level : assert property (@(posedge clk) disable iff (srst)
        rd_vld |-> (level != '0))
        else $error("fifo_core: rd_vld high with zero count");

endmodule : fifo_core

`default_nettype wire

// ==== design/fifo_prefetch.sv ====
// Prefetch buffer on top of fifo_core
// wr_rdy stays high while the FIFO has room for every read that may
// still be in flight, so writes landing up to PIPELINE_DEPTH cycles
// after wr_rdy falls are always accepted

`timescale 1ns/1ps
`default_nettype none

module fifo_prefetch #(
    parameter int                      DATA_WID       = 32,
    parameter int                      PIPELINE_DEPTH = 3,
    parameter prefetch_pkg::opt_mode_t WR_OPT_MODE    = prefetch_pkg::OPT_MODE_TIMING,
    parameter prefetch_pkg::opt_mode_t RD_OPT_MODE    = prefetch_pkg::OPT_MODE_TIMING
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                wr,
    input  logic [DATA_WID-1:0] wr_data,
    output logic                wr_rdy,
    input  logic                rd,
    output logic                rd_vld,
    output logic [DATA_WID-1:0] rd_data,
    output logic                oflow
);
    import prefetch_pkg::*;

    // ------------------------------------------------------------------------
    // Sizing
    // ------------------------------------------------------------------------
    // Write to head, count register plus output register in TIMING mode
    localparam int WR_TO_EMPTY_LATENCY = (WR_OPT_MODE == OPT_MODE_TIMING) ? 2 : 1;
    // Pop to freed slot
    localparam int RD_TO_FULL_LATENCY  = (RD_OPT_MODE == OPT_MODE_TIMING) ? 1 : 0;
    localparam int DEPTH = PIPELINE_DEPTH * 2 + 1 + WR_TO_EMPTY_LATENCY + RD_TO_FULL_LATENCY;
    localparam int CNT_WID = $clog2(DEPTH+2);
    localparam int RSV_WID = $clog2(PIPELINE_DEPTH+1);

    logic [CNT_WID-1:0]        count;
    // One bit per recent cycle, set where wr_rdy was high
    logic [PIPELINE_DEPTH-1:0] rdy_hist;
    logic [RSV_WID-1:0]        reserved;

    fifo_core #(
        .DATA_WID    (DATA_WID),
        .DEPTH       (DEPTH),
        .WR_OPT_MODE (WR_OPT_MODE),
        .RD_OPT_MODE (RD_OPT_MODE)
    ) u_fifo_core (
        .clk     (clk),
        .srst    (srst),
        .wr      (wr),
        .wr_data (wr_data),
        .rd      (rd),
        .count   (count),
        .rd_vld  (rd_vld),
        .rd_data (rd_data),
        .oflow   (oflow)
    );

    // ------------------------------------------------------------------------
    // In-flight reservation
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            rdy_hist <= '0;
        end else begin
            rdy_hist <= (rdy_hist << 1) | PIPELINE_DEPTH'(wr_rdy);
        end
    end

    // Each granted cycle may still deliver a word
    always_comb begin
        reserved = '0;
        for (int i = 0; i < PIPELINE_DEPTH; i++) begin
            reserved = reserved + RSV_WID'(rdy_hist[i]);
        end
    end

    // Registered permission, counts stored plus reserved slots
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_rdy <= 1'b0;
        end else begin
            wr_rdy <= (int'(count) + int'(reserved)) < (DEPTH - 1);
        end
    end

    // Reservation must cover every late write from the read pipeline
    a_no_oflow : assert property (@(posedge clk) disable iff (srst) !oflow)
        else $error("fifo_prefetch: write dropped, reservation too small");

endmodule : fifo_prefetch

`default_nettype wire

// ==== design/mem_rd_if.sv ====
// Read request and response bundle of the prefetcher
// The controller drives requests, the memory pipe answers them
// and the FIFO write side takes the responses through the sink view

`timescale 1ns/1ps
`default_nettype none

interface mem_rd_if #(
    parameter int ADDR_WID = 6,
    parameter int DATA_WID = 32
);

    // Request side, no ready signal
    logic                req;
    logic [ADDR_WID-1:0] addr;

    // Response side, fixed latency after req
    logic                rsp_vld;
    logic [DATA_WID-1:0] rsp_data;

    // Burst controller
    modport ctrl (
        output req,
        output addr
    );

    // Memory read pipeline
    modport mem (
        input  req,
        input  addr,
        output rsp_vld,
        output rsp_data
    );

    // Consumer of responses
    modport sink (
        input  rsp_vld,
        input  rsp_data
    );

endinterface : mem_rd_if

`default_nettype wire

// ==== design/mem_read_pipe.sv ====
// Data memory with a host load port and a fixed-latency read path
// A request answers exactly PIPELINE_DEPTH cycles later, one read can
// start every cycle so several are in flight at once

`timescale 1ns/1ps
`default_nettype none

module mem_read_pipe #(
    parameter int ADDR_WID       = 6,
    parameter int DATA_WID       = 32,
    parameter int PIPELINE_DEPTH = 3
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                load_en,
    input  logic [ADDR_WID-1:0] load_addr,
    input  logic [DATA_WID-1:0] load_data,
    mem_rd_if.mem               rd
);
    localparam int MEM_WORDS = 2**ADDR_WID;

    logic [DATA_WID-1:0]       mem [MEM_WORDS];
    logic [PIPELINE_DEPTH-1:0] stage_vld;
    logic [DATA_WID-1:0]       stage_data [PIPELINE_DEPTH];

    // Host load, only while the controller is idle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // ------------------------------------------------------------------------
    // Read pipeline
    // ------------------------------------------------------------------------
    // First stage is the synchronous memory read
    always_ff @(posedge clk) begin
        if (rd.req) begin
            stage_data[0] <= mem[rd.addr];
        end
        for (int i = 1; i < PIPELINE_DEPTH; i++) begin
            stage_data[i] <= stage_data[i-1];
        end
    end

    // Valid bits travel alongside the data
    always_ff @(posedge clk) begin
        if (srst) begin
            stage_vld <= '0;
        end else begin
            stage_vld <= (stage_vld << 1) | PIPELINE_DEPTH'(rd.req);
        end
    end

    assign rd.rsp_vld  = stage_vld[PIPELINE_DEPTH-1];
    assign rd.rsp_data = stage_data[PIPELINE_DEPTH-1];

endmodule : mem_read_pipe

`default_nettype wire

// ==== design/prefetch_ctrl.sv ====
// Burst controller of the read prefetcher
// Takes a start address and a word count, issues one read per cycle
// while the FIFO grants room, then waits for the pipeline to empty
// busy is high from the cycle after start until the last word is stored

`timescale 1ns/1ps
`default_nettype none

module prefetch_ctrl #(
    parameter int ADDR_WID       = 6,
    parameter int LEN_WID        = 8,
    parameter int PIPELINE_DEPTH = 3
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                start,
    input  logic [ADDR_WID-1:0] start_addr,
    input  logic [LEN_WID-1:0]  length,
    input  logic                wr_rdy,
    output logic                busy,
    mem_rd_if.ctrl              rd,
    output logic                cnt_load,
    output logic [LEN_WID-1:0]  cnt_load_val,
    output logic                cnt_dec,
    input  logic                cnt_zero
);
    import prefetch_pkg::*;

    // Two cycles pass between the last read and the start of the wait,
    // so busy falls PIPELINE_DEPTH+1 cycles after the last read
    localparam int DRAIN_WAIT = (PIPELINE_DEPTH > 2) ? PIPELINE_DEPTH - 2 : 0;

    ctrl_state_t         state;
    ctrl_state_t         state_nxt;
    logic [ADDR_WID-1:0] addr_q;
    logic                issue;

    assign busy    = (state != IDLE);
    assign issue   = (state == FETCH) && wr_rdy && !cnt_zero;
    assign rd.req  = issue;
    assign rd.addr = addr_q;

    // ------------------------------------------------------------------------
    // Next state and counter control
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt    = state;
        cnt_load     = 1'b0;
        cnt_load_val = length;
        cnt_dec      = 1'b0;
        unique case (state)
            IDLE: begin
                if (start) begin
                    cnt_load = 1'b1;
                    // Nothing to read, skip to the wait
                    if (length == '0) begin
                        cnt_load_val = LEN_WID'(DRAIN_WAIT);
                        state_nxt    = DRAIN;
                    end else begin
                        state_nxt = FETCH;
                    end
                end
            end
            FETCH: begin
                cnt_dec = issue;
                if (cnt_zero) begin
                    cnt_load     = 1'b1;
                    cnt_load_val = LEN_WID'(DRAIN_WAIT);
                    state_nxt    = DRAIN;
                end
            end
            DRAIN: begin
                cnt_dec = !cnt_zero;
                if (cnt_zero) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Address wraps naturally at the memory size
    always_ff @(posedge clk) begin
        if ((state == IDLE) && start) begin
            addr_q <= start_addr;
        end else if (issue) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    // Host must wait for busy to fall before the next command
    a_start_when_idle : assert property (@(posedge clk) disable iff (srst)
        busy |-> !start)
        else $error("prefetch_ctrl: start while busy");

endmodule : prefetch_ctrl

`default_nettype wire

// ==== design/prefetch_pkg.sv ====
// Shared types for the memory read prefetcher
// Holds the FIFO count update mode and the burst controller states
// Modules take these by a wildcard import in their body

`default_nettype none

package prefetch_pkg;

    // ------------------------------------------------------------------------
    // FIFO count update mode
    // ------------------------------------------------------------------------
    // TIMING registers count updates, LATENCY takes them combinationally
    typedef enum logic [0:0] {
        OPT_MODE_TIMING  = 1'b0,
        OPT_MODE_LATENCY = 1'b1
    } opt_mode_t;

    // ------------------------------------------------------------------------
    // Burst controller states
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        FETCH = 2'd1,
        DRAIN = 2'd2
    } ctrl_state_t;

endpackage : prefetch_pkg

`default_nettype wire

// ==== design/read_prefetcher.sv ====
// Top level of the memory read prefetcher
// The host loads the memory, then starts a burst with an address and
// a word count; the words come out in address order on out_vld/out_data
// and are popped with out_rd

`timescale 1ns/1ps
`default_nettype none

module read_prefetcher #(
    parameter int                      DATA_WID       = 32,
    parameter int                      ADDR_WID       = 6,
    parameter int                      LEN_WID        = 8,
    parameter int                      PIPELINE_DEPTH = 3,
    parameter prefetch_pkg::opt_mode_t OPT_MODE       = prefetch_pkg::OPT_MODE_TIMING
) (
    input  logic                clk,
    input  logic                srst,
    // Load port
    input  logic                load_en,
    input  logic [ADDR_WID-1:0] load_addr,
    input  logic [DATA_WID-1:0] load_data,
    // Burst command
    input  logic                start,
    input  logic [ADDR_WID-1:0] start_addr,
    input  logic [LEN_WID-1:0]  length,
    output logic                busy,
    // Consumer side
    output logic                out_vld,
    output logic [DATA_WID-1:0] out_data,
    input  logic                out_rd,
    output logic                oflow
);
    logic               wr_rdy;
    logic               cnt_load;
    logic [LEN_WID-1:0] cnt_load_val;
    logic               cnt_dec;
    logic               cnt_zero;

    mem_rd_if #(.ADDR_WID(ADDR_WID), .DATA_WID(DATA_WID)) rd_if ();

    prefetch_ctrl #(
        .ADDR_WID       (ADDR_WID),
        .LEN_WID        (LEN_WID),
        .PIPELINE_DEPTH (PIPELINE_DEPTH)
    ) u_ctrl (
        .clk          (clk),
        .srst         (srst),
        .start        (start),
        .start_addr   (start_addr),
        .length       (length),
        .wr_rdy       (wr_rdy),
        .busy         (busy),
        .rd           (rd_if.ctrl),
        .cnt_load     (cnt_load),
        .cnt_load_val (cnt_load_val),
        .cnt_dec      (cnt_dec),
        .cnt_zero     (cnt_zero)
    );

    burst_counter #(.WID(LEN_WID)) u_counter (
        .clk      (clk),
        .srst     (srst),
        .load     (cnt_load),
        .load_val (cnt_load_val),
        .dec      (cnt_dec),
        .zero     (cnt_zero)
    );

    mem_read_pipe #(
        .ADDR_WID       (ADDR_WID),
        .DATA_WID       (DATA_WID),
        .PIPELINE_DEPTH (PIPELINE_DEPTH)
    ) u_mem (
        .clk       (clk),
        .srst      (srst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd        (rd_if.mem)
    );

    // Responses feed the FIFO write side directly
    fifo_prefetch #(
        .DATA_WID       (DATA_WID),
        .PIPELINE_DEPTH (PIPELINE_DEPTH),
        .WR_OPT_MODE    (OPT_MODE),
        .RD_OPT_MODE    (OPT_MODE)
    ) u_fifo (
        .clk     (clk),
        .srst    (srst),
        .wr      (rd_if.rsp_vld),
        .wr_data (rd_if.rsp_data),
        .wr_rdy  (wr_rdy),
        .rd      (out_rd),
        .rd_vld  (out_vld),
        .rd_data (out_data),
        .oflow   (oflow)
    );

endmodule : read_prefetcher

`default_nettype wire

// ==== sim.f ====
design/prefetch_pkg.sv
design/mem_rd_if.sv
design/fifo_core.sv
design/fifo_prefetch.sv
design/mem_read_pipe.sv
design/burst_counter.sv
design/prefetch_ctrl.sv
design/read_prefetcher.sv
verification/tb_read_prefetcher.sv

// ==== verification/tb_read_prefetcher.sv ====
// Self-checking testbench for the memory read prefetcher
// Loads the memory with random words, runs bursts under several consumer
// patterns and compares every popped word with a shadow memory model
// All DUT inputs change on the falling clock edge

`timescale 1ns/1ps
`default_nettype none

module tb_read_prefetcher;

    localparam int DATA_WID       = 32;
    localparam int ADDR_WID       = 6;
    localparam int LEN_WID        = 8;
    localparam int PIPELINE_DEPTH = 3;
    localparam int MEM_WORDS      = 2**ADDR_WID;

    // Consumer patterns for out_rd
    localparam int RD_ALWAYS = 0;
    localparam int RD_HOLD   = 1;
    localparam int RD_RANDOM = 2;

    // Cycle limits for the wait loops
    localparam int IDLE_TIMEOUT  = 500;
    localparam int DRAIN_TIMEOUT = 500;

    logic                clk;
    logic                srst;
    logic                load_en;
    logic [ADDR_WID-1:0] load_addr;
    logic [DATA_WID-1:0] load_data;
    logic                start;
    logic [ADDR_WID-1:0] start_addr;
    logic [LEN_WID-1:0]  length;
    logic                busy;
    logic                out_vld;
    logic [DATA_WID-1:0] out_data;
    logic                out_rd;
    logic                oflow;

    // Shadow of the DUT memory and the words still expected
    logic [DATA_WID-1:0] shadow [MEM_WORDS];
    logic [DATA_WID-1:0] exp_q [$];
    int                  rd_mode;

    read_prefetcher #(
        .DATA_WID       (DATA_WID),
        .ADDR_WID       (ADDR_WID),
        .LEN_WID        (LEN_WID),
        .PIPELINE_DEPTH (PIPELINE_DEPTH)
    ) UUT (
        .clk        (clk),
        .srst       (srst),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .start      (start),
        .start_addr (start_addr),
        .length     (length),
        .busy       (busy),
        .out_vld    (out_vld),
        .out_data   (out_data),
        .out_rd     (out_rd),
        .oflow      (oflow)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // Reference model and reporting
    // ------------------------------------------------------------------------
    // Word number idx of a burst
    // Address wraps at the memory size
    function automatic logic [DATA_WID-1:0] ref_word(input int base, input int idx);
        return shadow[(base + idx) % MEM_WORDS];
    endfunction

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [DATA_WID-1:0] actual,
                             input logic [DATA_WID-1:0] expected);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s got=%h expected=%h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // Every popped word must be the oldest expected one
    // oflow must stay low in every cycle
    always @(posedge clk) begin
        if (!srst) begin
            check_val("oflow", DATA_WID'(oflow), '0);
            if (out_vld && out_rd) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: t=%0t output word %h with nothing expected",
                             $time, out_data);
                    stop_with_failure();
                end else begin
                    check_val("out_data", out_data, exp_q.pop_front());
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    // Advance to the next falling edge and drive out_rd by the current pattern
    task automatic tick();
        @(negedge clk);
        case (rd_mode)
            RD_ALWAYS: out_rd = 1'b1;
            RD_HOLD:   out_rd = 1'b0;
            default:   out_rd = (($urandom % 4) != 0);
        endcase
    endtask

    task automatic load_memory();
        for (int a = 0; a < MEM_WORDS; a++) begin
            tick();
            load_en   = 1'b1;
            load_addr = ADDR_WID'(a);
            load_data = $urandom;
            shadow[a] = load_data;
        end
        tick();
        load_en = 1'b0;
    endtask

    // Called at a falling edge with busy low
    task automatic start_burst(input int base, input int len);
        start      = 1'b1;
        start_addr = ADDR_WID'(base);
        length     = LEN_WID'(len);
        for (int i = 0; i < len; i++) begin
            exp_q.push_back(ref_word(base, i));
        end
        tick();
        start = 1'b0;
    endtask

    task automatic wait_idle(input bit no_vld);
        int cycles;
        cycles = 0;
        while (busy) begin
            if (no_vld) begin
                check_val("out_vld", DATA_WID'(out_vld), '0);
            end
            if (cycles >= IDLE_TIMEOUT) begin
                $display("ERROR: busy still high after %0d cycles", cycles);
                stop_with_failure();
            end else begin
                tick();
                cycles++;
            end
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            if (cycles >= DRAIN_TIMEOUT) begin
                $display("ERROR: %0d words never came out of the FIFO", exp_q.size());
                stop_with_failure();
            end else begin
                tick();
                cycles++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Scenarios
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'hbbbd1693));
        clk        = 1'b0;
        srst       = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        start      = 1'b0;
        start_addr = '0;
        length     = '0;
        out_rd     = 1'b0;
        rd_mode    = RD_ALWAYS;
        repeat (3) tick();
        srst = 1'b0;

        // Idle outputs after reset, then a plain burst
        check_val("busy", DATA_WID'(busy), '0);
        check_val("out_vld", DATA_WID'(out_vld), '0);
        check_val("oflow", DATA_WID'(oflow), '0);
        load_memory();
        start_burst(5, 10);
        wait_idle(1'b0);
        wait_drained();

        // Consumer stalled long enough to fill the FIFO
        rd_mode = RD_HOLD;
        start_burst(20, 40);
        repeat (30) tick();
        rd_mode = RD_RANDOM;
        wait_idle(1'b0);
        wait_drained();

        // Wrap from the top of the memory to address 0
        start_burst(60, 10);
        wait_idle(1'b0);
        wait_drained();

        // Zero length only passes through the drain wait
        rd_mode = RD_ALWAYS;
        start_burst(7, 0);
        check_val("busy", DATA_WID'(busy), 1);
        wait_idle(1'b1);
        repeat (4) begin
            check_val("out_vld", DATA_WID'(out_vld), '0);
            tick();
        end

        // Second start on the edge where busy falls
        rd_mode = RD_RANDOM;
        start_burst(10, 12);
        wait_idle(1'b0);
        start_burst(30, 15);
        wait_idle(1'b0);
        wait_drained();

        // Reset with words queued and reads in flight
        rd_mode = RD_HOLD;
        start_burst(40, 20);
        repeat (8) tick();
        srst = 1'b1;
        exp_q.delete();
        repeat (2) tick();
        srst = 1'b0;
        check_val("busy", DATA_WID'(busy), '0);
        check_val("out_vld", DATA_WID'(out_vld), '0);
        rd_mode = RD_RANDOM;
        start_burst(50, 16);
        wait_idle(1'b0);
        wait_drained();

        repeat (5) tick();
        if (!out_vld) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("ERROR: data left over at the end of the run");
            stop_with_failure();
        end
    end

endmodule : tb_read_prefetcher

`default_nettype wire
